// File: src/capi_pkg.sv
package capi_pkg;

  // Host link widths
  localparam int addr_width = 24;
  localparam int data_width = 64;

  // Parity convention on the link, 1 selects odd parity
  localparam logic odd_parity = 1'b1;

  // MMIO register word addresses
  localparam logic [addr_width-1:0] reg_scratch    = 24'h00_0010;
  localparam logic [addr_width-1:0] reg_read_count = 24'h00_0012;

  localparam logic [data_width-1:0] read_count_step = 64'd1;

  // One-hot request kind bit positions
  localparam int kind_cfg_read   = 0;
  localparam int kind_cfg_write  = 1;
  localparam int kind_mmio_read  = 2;
  localparam int kind_mmio_write = 3;
  localparam int kind_width      = 4;

  // Descriptor size in doublewords
  localparam int desc_words        = 8;
  localparam int desc_offset_width = $clog2(desc_words);

  // Descriptor field values
  localparam logic [15:0] desc_num_ints_per_process = 16'h0000;
  localparam logic [15:0] desc_num_of_processes     = 16'h0001;
  localparam logic [15:0] desc_num_of_afu_crs       = 16'h0001;
  // Dedicated process model
  localparam logic [15:0] desc_req_prog_model       = 16'h8010;
  localparam logic [55:0] desc_afu_cr_len           = 56'h00_0000_0000_0001;
  localparam logic [63:0] desc_afu_cr_offset        = 64'h0000_0000_0000_0100;
  localparam logic        desc_psa_per_process_req  = 1'b0;
  localparam logic        desc_psa_required         = 1'b1;
  localparam logic [55:0] desc_psa_length           = 56'h00_0000_0000_0000;
  localparam logic [63:0] desc_psa_offset           = 64'h0000_0000_0000_0000;
  localparam logic [55:0] desc_afu_eb_len           = 56'h00_0000_0000_0000;
  localparam logic [63:0] desc_afu_eb_offset        = 64'h0000_0000_0000_0000;

  // Doublewords in configuration space order
  localparam logic [data_width-1:0] desc_table [desc_words] = '{
    {desc_num_ints_per_process,
     desc_num_of_processes,
     desc_num_of_afu_crs,
     desc_req_prog_model},
    64'h0000_0000_0000_0000,
    {8'h00, desc_afu_cr_len},
    desc_afu_cr_offset,
    {6'b00_0000,
     desc_psa_per_process_req,
     desc_psa_required,
     desc_psa_length},
    desc_psa_offset,
    {8'h00, desc_afu_eb_len},
    desc_afu_eb_offset
  };

endpackage

// File: src/parity.sv
`timescale 1ns/1ps

module parity #(
  parameter type data_t = logic [63:0]
) (
  input  logic  clock,
  input  data_t data,
  input  logic  odd,
  output logic  par
);

  // Odd mode makes the total count of ones odd
  always_ff @(posedge clock) begin
    par <= (^data) ^ odd;
  end

endmodule

// File: src/afu_descriptor.sv
`timescale 1ns/1ps

module afu_descriptor (
  input  logic                                     clock,
  input  logic                                     rstn,
  input  logic [capi_pkg::desc_offset_width-1:0]   offset,
  output logic [capi_pkg::data_width-1:0]          rdata
);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rdata <= '0;
    end else if (int'(offset) < capi_pkg::desc_words) begin
      rdata <= capi_pkg::desc_table[offset];
    end else begin
      rdata <= '0;
    end
  end

  offset_known: assert property (
    @(posedge clock) disable iff (!rstn)
    !$isunknown(offset)
  ) else $error("descriptor offset is unknown");

endmodule

// File: src/mmio_parity_check.sv
`timescale 1ns/1ps

module mmio_parity_check (
  input  logic                              clock,
  input  logic                              rstn,
  input  logic                              valid,
  input  logic                              write,
  input  logic [capi_pkg::addr_width-1:0]   address,
  input  logic                              address_parity,
  input  logic [capi_pkg::data_width-1:0]   wdata,
  input  logic                              wdata_parity,
  output logic [1:0]                        errors
);

  logic       address_parity_calc;
  logic       wdata_parity_calc;
  logic       address_parity_recv;
  logic       wdata_parity_recv;
  logic       valid_d;
  logic       write_d;
  logic [1:0] flags;
  logic [1:0] flags_d;

  parity #(
    .data_t (logic [capi_pkg::addr_width-1:0])
  ) address_parity_gen (
    .clock (clock),
    .data  (address),
    .odd   (capi_pkg::odd_parity),
    .par   (address_parity_calc)
  );

  parity #(
    .data_t (logic [capi_pkg::data_width-1:0])
  ) wdata_parity_gen (
    .clock (clock),
    .data  (wdata),
    .odd   (capi_pkg::odd_parity),
    .par   (wdata_parity_calc)
  );

  // Received bits wait one cycle beside the computed ones
  always_ff @(posedge clock) begin
    address_parity_recv <= address_parity;
    wdata_parity_recv   <= wdata_parity;
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      valid_d <= 1'b0;
      write_d <= 1'b0;
      flags   <= 2'b00;
      flags_d <= 2'b00;
      errors  <= 2'b00;
    end else begin
      valid_d  <= valid;
      write_d  <= write;
      // Data parity only counts on writes
      flags[1] <= valid_d && write_d && (wdata_parity_calc != wdata_parity_recv);
      flags[0] <= valid_d && (address_parity_calc != address_parity_recv);
      flags_d  <= flags;
      errors   <= flags_d;
    end
  end

  errors_need_request: assert property (
    @(posedge clock) disable iff (!rstn)
    !$past(valid, 4) |-> (errors == 2'b00)
  ) else $error("parity error flagged without a request");

endmodule

// File: src/mmio.sv
`timescale 1ns/1ps

module mmio (
  input  logic                                     clock,
  input  logic                                     rstn,
  input  logic                                     mmio_valid,
  input  logic                                     mmio_cfg,
  input  logic                                     mmio_read,
  input  logic                                     mmio_doubleword,
  input  logic [capi_pkg::addr_width-1:0]          mmio_address,
  input  logic                                     mmio_address_parity,
  input  logic [capi_pkg::data_width-1:0]          mmio_wdata,
  input  logic                                     mmio_wdata_parity,
  output logic [capi_pkg::desc_offset_width-1:0]   desc_offset,
  input  logic [capi_pkg::data_width-1:0]          desc_rdata,
  output logic                                     chk_valid,
  output logic                                     chk_write,
  output logic [capi_pkg::addr_width-1:0]          chk_address,
  output logic                                     chk_address_parity,
  output logic [capi_pkg::data_width-1:0]          chk_wdata,
  output logic                                     chk_wdata_parity,
  output logic                                     mmio_ack,
  output logic [capi_pkg::data_width-1:0]          mmio_rdata,
  output logic                                     mmio_rdata_parity
);

  logic [capi_pkg::kind_width-1:0] req_kind;
  logic [capi_pkg::kind_width-1:0] s1_kind;
  logic [capi_pkg::kind_width-1:0] s2_kind;
  logic [capi_pkg::kind_width-1:0] s3_kind;
  logic                            s1_doubleword;
  logic                            s2_doubleword;
  logic                            s3_doubleword;
  logic [capi_pkg::addr_width-1:0] s1_address;
  logic [capi_pkg::addr_width-1:0] s2_address;
  logic                            s3_addr_lsb;
  logic [capi_pkg::data_width-1:0] s1_wdata;
  logic [capi_pkg::data_width-1:0] s2_wdata;
  logic                            s1_address_parity;
  logic                            s1_wdata_parity;
  logic [capi_pkg::data_width-1:0] s3_rdata;
  logic                            desc_hit;
  logic [capi_pkg::data_width-1:0] scratch;
  logic [capi_pkg::data_width-1:0] read_count;
  logic [capi_pkg::data_width-1:0] data_out;
  logic                            data_ack;

  always_comb begin
    req_kind = '0;
    if (mmio_valid) begin
      case ({mmio_cfg, mmio_read})
        2'b11:   req_kind[capi_pkg::kind_cfg_read]   = 1'b1;
        2'b10:   req_kind[capi_pkg::kind_cfg_write]  = 1'b1;
        2'b01:   req_kind[capi_pkg::kind_mmio_read]  = 1'b1;
        default: req_kind[capi_pkg::kind_mmio_write] = 1'b1;
      endcase
    end
  end

  // Stage 1
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s1_kind <= '0;
    end else begin
      s1_kind <= req_kind;
    end
  end

  always_ff @(posedge clock) begin
    s1_doubleword     <= mmio_doubleword;
    s1_address        <= mmio_address;
    s1_wdata          <= mmio_wdata;
    s1_address_parity <= mmio_address_parity;
    s1_wdata_parity   <= mmio_wdata_parity;
  end

  // Doubleword index within configuration space
  assign desc_offset = s1_kind[capi_pkg::kind_cfg_read] ?
                       s1_address[capi_pkg::desc_offset_width:1] : '0;

  assign chk_valid          = |s1_kind;
  assign chk_write          = s1_kind[capi_pkg::kind_cfg_write] |
                              s1_kind[capi_pkg::kind_mmio_write];
  assign chk_address        = s1_address;
  assign chk_address_parity = s1_address_parity;
  assign chk_wdata          = s1_wdata;
  assign chk_wdata_parity   = s1_wdata_parity;

  // Stage 2
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s2_kind <= '0;
    end else begin
      s2_kind <= s1_kind;
    end
  end

  always_ff @(posedge clock) begin
    s2_doubleword <= s1_doubleword;
    s2_address    <= s1_address;
    s2_wdata      <= s1_wdata;
  end

  // Addresses past the descriptor read as zero
  assign desc_hit = (s2_address[capi_pkg::addr_width-1:capi_pkg::desc_offset_width+1] == '0);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      scratch    <= '0;
      read_count <= '0;
    end else if (s2_kind[capi_pkg::kind_mmio_write]) begin
      if (s2_address == capi_pkg::reg_scratch) begin
        scratch <= s2_wdata;
      end
      if (s2_address == capi_pkg::reg_read_count) begin
        read_count <= s2_wdata;
      end
    end else if (s2_kind[capi_pkg::kind_mmio_read] &&
                 s2_address == capi_pkg::reg_read_count) begin
      read_count <= read_count + capi_pkg::read_count_step;
    end
  end

  // Stage 3
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s3_kind <= '0;
    end else begin
      s3_kind <= s2_kind;
    end
  end

  always_ff @(posedge clock) begin
    s3_doubleword <= s2_doubleword;
    s3_addr_lsb   <= s2_address[0];
    if (s2_kind[capi_pkg::kind_cfg_read] && desc_hit) begin
      s3_rdata <= desc_rdata;
    end else if (s2_kind[capi_pkg::kind_mmio_read]) begin
      case (s2_address)
        capi_pkg::reg_scratch:    s3_rdata <= scratch;
        // Old count goes out while the register steps
        capi_pkg::reg_read_count: s3_rdata <= read_count;
        default:                  s3_rdata <= '0;
      endcase
    end else begin
      s3_rdata <= '0;
    end
  end

  // Stage 4, read data select
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      data_out <= '0;
      data_ack <= 1'b0;
    end else begin
      data_ack <= |s3_kind;
      if (s3_kind[capi_pkg::kind_cfg_read]) begin
        if (s3_doubleword) begin
          data_out <= s3_rdata;
        end else if (s3_addr_lsb) begin
          data_out <= {2{s3_rdata[31:0]}};
        end else begin
          data_out <= {2{s3_rdata[63:32]}};
        end
      end else if (s3_kind[capi_pkg::kind_mmio_read]) begin
        data_out <= s3_rdata;
      end else begin
        data_out <= '0;
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      mmio_ack   <= 1'b0;
      mmio_rdata <= '0;
    end else begin
      mmio_ack   <= data_ack;
      mmio_rdata <= data_out;
    end
  end

  // Parity lands in the same cycle as mmio_rdata
  parity #(
    .data_t (logic [capi_pkg::data_width-1:0])
  ) rdata_parity_gen (
    .clock (clock),
    .data  (data_out),
    .odd   (capi_pkg::odd_parity),
    .par   (mmio_rdata_parity)
  );

  ack_known: assert property (
    @(posedge clock) disable iff (!rstn)
    !$isunknown(mmio_ack)
  ) else $error("mmio_ack is unknown");

  kind_onehot: assert property (
    @(posedge clock) disable iff (!rstn)
    $onehot0(s1_kind) && $onehot0(s2_kind) && $onehot0(s3_kind)
  ) else $error("request kind is not one-hot");

endmodule

// File: src/afu_top.sv
`timescale 1ns/1ps

module afu_top (
  input  logic                              clock,
  input  logic                              rstn,
  input  logic                              mmio_valid,
  input  logic                              mmio_cfg,
  input  logic                              mmio_read,
  input  logic                              mmio_doubleword,
  input  logic [capi_pkg::addr_width-1:0]   mmio_address,
  input  logic                              mmio_address_parity,
  input  logic [capi_pkg::data_width-1:0]   mmio_wdata,
  input  logic                              mmio_wdata_parity,
  output logic                              mmio_ack,
  output logic [capi_pkg::data_width-1:0]   mmio_rdata,
  output logic                              mmio_rdata_parity,
  output logic [1:0]                        mmio_errors
);

  logic [capi_pkg::desc_offset_width-1:0] desc_offset;
  logic [capi_pkg::data_width-1:0]        desc_rdata;
  logic                                   chk_valid;
  logic                                   chk_write;
  logic [capi_pkg::addr_width-1:0]        chk_address;
  logic                                   chk_address_parity;
  logic [capi_pkg::data_width-1:0]        chk_wdata;
  logic                                   chk_wdata_parity;

  mmio mmio_inst (
    .clock               (clock),
    .rstn                (rstn),
    .mmio_valid          (mmio_valid),
    .mmio_cfg            (mmio_cfg),
    .mmio_read           (mmio_read),
    .mmio_doubleword     (mmio_doubleword),
    .mmio_address        (mmio_address),
    .mmio_address_parity (mmio_address_parity),
    .mmio_wdata          (mmio_wdata),
    .mmio_wdata_parity   (mmio_wdata_parity),
    .desc_offset         (desc_offset),
    .desc_rdata          (desc_rdata),
    .chk_valid           (chk_valid),
    .chk_write           (chk_write),
    .chk_address         (chk_address),
    .chk_address_parity  (chk_address_parity),
    .chk_wdata           (chk_wdata),
    .chk_wdata_parity    (chk_wdata_parity),
    .mmio_ack            (mmio_ack),
    .mmio_rdata          (mmio_rdata),
    .mmio_rdata_parity   (mmio_rdata_parity)
  );

  afu_descriptor desc_inst (
    .clock  (clock),
    .rstn   (rstn),
    .offset (desc_offset),
    .rdata  (desc_rdata)
  );

  mmio_parity_check check_inst (
    .clock          (clock),
    .rstn           (rstn),
    .valid          (chk_valid),
    .write          (chk_write),
    .address        (chk_address),
    .address_parity (chk_address_parity),
    .wdata          (chk_wdata),
    .wdata_parity   (chk_wdata_parity),
    .errors         (mmio_errors)
  );

endmodule

// File: tb/afu_tb_table.svh
`ifndef afu_tb_table_svh
`define afu_tb_table_svh

// One host request, its parity faults and the expected response
typedef struct {
  logic        cfg;
  logic        read;
  logic        doubleword;
  logic [23:0] address;
  logic [63:0] wdata;
  logic [1:0]  bad_par;
  logic [63:0] exp_rdata;
  logic [1:0]  exp_errors;
} request_t;

request_t    requests[$];
logic [63:0] lcg_state;
logic [63:0] model_scratch;
logic [63:0] model_read_count;

function automatic logic [63:0] lcg_next();
  lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
  return lcg_state;
endfunction

task automatic add_request(input logic cfg, input logic read, input logic doubleword,
                           input logic [23:0] address, input logic [1:0] bad_par);
  request_t    req;
  logic [63:0] dword;
  req.cfg        = cfg;
  req.read       = read;
  req.doubleword = doubleword;
  req.address    = address;
  req.wdata      = lcg_next();
  req.bad_par    = bad_par;
  req.exp_rdata  = '0;
  // Data parity only matters on writes
  req.exp_errors = {bad_par[1] & ~read, bad_par[0]};
  dword          = '0;
  if (cfg && read) begin
    if (address < 24'(2 * capi_pkg::desc_words)) begin
      dword = capi_pkg::desc_table[address[3:1]];
    end
    if (doubleword) begin
      req.exp_rdata = dword;
    end else if (address[0]) begin
      req.exp_rdata = {2{dword[31:0]}};
    end else begin
      // Even word address selects the upper half
      req.exp_rdata = {2{dword[63:32]}};
    end
  end else if (!cfg && read) begin
    if (address == capi_pkg::reg_scratch) begin
      req.exp_rdata = model_scratch;
    end else if (address == capi_pkg::reg_read_count) begin
      req.exp_rdata    = model_read_count;
      model_read_count = model_read_count + 64'd1;
    end
  end else if (!cfg) begin
    if (address == capi_pkg::reg_scratch) begin
      model_scratch = req.wdata;
    end else if (address == capi_pkg::reg_read_count) begin
      model_read_count = req.wdata;
    end
  end
  requests.push_back(req);
endtask

task automatic build_requests();
  lcg_state        = 64'd8;
  model_scratch    = '0;
  model_read_count = '0;
  // Every descriptor doubleword, then the first offset past the table
  for (int i = 0; i <= 2 * capi_pkg::desc_words; i += 2) begin
    add_request(1'b1, 1'b1, 1'b1, 24'(i), 2'b00);
  end
  for (int i = 0; i < 6; i++) begin
    add_request(1'b1, 1'b1, 1'b0, 24'(i), 2'b00);
  end
  add_request(1'b1, 1'b0, 1'b1, 24'h00_0002, 2'b00);
  // Scratch, with a read right after the write
  add_request(1'b0, 1'b1, 1'b1, capi_pkg::reg_scratch, 2'b00);
  add_request(1'b0, 1'b0, 1'b1, capi_pkg::reg_scratch, 2'b00);
  add_request(1'b0, 1'b1, 1'b1, capi_pkg::reg_scratch, 2'b00);
  add_request(1'b0, 1'b0, 1'b1, 24'h00_0020, 2'b00);
  add_request(1'b0, 1'b1, 1'b1, capi_pkg::reg_scratch, 2'b00);
  add_request(1'b0, 1'b1, 1'b1, 24'h00_0020, 2'b00);
  for (int i = 0; i < 3; i++) begin
    add_request(1'b0, 1'b1, 1'b1, capi_pkg::reg_read_count, 2'b00);
  end
  add_request(1'b0, 1'b0, 1'b1, capi_pkg::reg_read_count, 2'b00);
  add_request(1'b0, 1'b1, 1'b1, capi_pkg::reg_read_count, 2'b00);
  add_request(1'b0, 1'b1, 1'b1, capi_pkg::reg_read_count, 2'b00);
  // Parity faults
  add_request(1'b0, 1'b1, 1'b1, capi_pkg::reg_scratch, 2'b01);
  add_request(1'b0, 1'b0, 1'b1, capi_pkg::reg_scratch, 2'b10);
  add_request(1'b0, 1'b1, 1'b1, capi_pkg::reg_scratch, 2'b10);
  add_request(1'b0, 1'b0, 1'b1, capi_pkg::reg_read_count, 2'b11);
  add_request(1'b0, 1'b1, 1'b1, capi_pkg::reg_read_count, 2'b00);
  add_request(1'b1, 1'b1, 1'b1, 24'h00_0006, 2'b01);
endtask

`endif

// File: tb/afu_top_tb.sv
`timescale 1ns/1ps

module afu_top_tb;

  logic        clock;
  logic        rstn;
  logic        mmio_valid;
  logic        mmio_cfg;
  logic        mmio_read;
  logic        mmio_doubleword;
  logic [23:0] mmio_address;
  logic        mmio_address_parity;
  logic [63:0] mmio_wdata;
  logic        mmio_wdata_parity;
  logic        mmio_ack;
  logic [63:0] mmio_rdata;
  logic        mmio_rdata_parity;
  logic [1:0]  mmio_errors;

  int drive_index;
  int cycle;
  int timeout_limit;
  int error_count;
  int ack_count;
  int response_count;
  int pending_index[$];
  int pending_due[$];

  `include "afu_tb_table.svh"

  afu_top uut (
    .clock               (clock),
    .rstn                (rstn),
    .mmio_valid          (mmio_valid),
    .mmio_cfg            (mmio_cfg),
    .mmio_read           (mmio_read),
    .mmio_doubleword     (mmio_doubleword),
    .mmio_address        (mmio_address),
    .mmio_address_parity (mmio_address_parity),
    .mmio_wdata          (mmio_wdata),
    .mmio_wdata_parity   (mmio_wdata_parity),
    .mmio_ack            (mmio_ack),
    .mmio_rdata          (mmio_rdata),
    .mmio_rdata_parity   (mmio_rdata_parity),
    .mmio_errors         (mmio_errors)
  );

  always #10 clock = ~clock;

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic drive_request(input int i);
    drive_index         = i;
    mmio_valid          = 1'b1;
    mmio_cfg            = requests[i].cfg;
    mmio_read           = requests[i].read;
    mmio_doubleword     = requests[i].doubleword;
    mmio_address        = requests[i].address;
    mmio_wdata          = requests[i].wdata;
    // Odd parity, flipped where the entry injects a fault
    mmio_address_parity = (~^requests[i].address) ^ requests[i].bad_par[0];
    mmio_wdata_parity   = (~^requests[i].wdata) ^ requests[i].bad_par[1];
  endtask

  // Requests sampled here are answered 4 edges later
  always @(posedge clock) begin
    if (rstn) begin
      cycle++;
      if (mmio_valid) begin
        pending_index.push_back(drive_index);
        pending_due.push_back(cycle + 4);
      end
    end
  end

  always @(negedge clock) begin
    int k;
    if (rstn) begin
      if (pending_due.size() > 0 && pending_due[0] == cycle) begin
        k = pending_index[0];
        if (mmio_ack !== 1'b1) begin
          error_count++;
          $display("No ack arrived for request %0d", k);
        end else begin
          ack_count++;
          check_value("mmio_rdata", mmio_rdata, requests[k].exp_rdata);
          check_value("mmio_rdata_parity", 64'(mmio_rdata_parity),
                      64'(~^requests[k].exp_rdata));
          check_value("mmio_errors", 64'(mmio_errors), 64'(requests[k].exp_errors));
        end
        response_count++;
        void'(pending_index.pop_front());
        void'(pending_due.pop_front());
      end else begin
        if (mmio_ack !== 1'b0) begin
          error_count++;
          $display("Ack seen in cycle %0d with no request due", cycle);
        end
        check_value("mmio_errors", 64'(mmio_errors), 64'd0);
        check_value("mmio_rdata", mmio_rdata, 64'd0);
      end
    end
  end

  always @(negedge clock) begin
    if (cycle > timeout_limit) begin
      $display("Timeout after %0d cycles, %0d of %0d responses seen",
               cycle, response_count, requests.size());
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    clock               = 1'b0;
    rstn                = 1'b0;
    mmio_valid          = 1'b0;
    mmio_cfg            = 1'b0;
    mmio_read           = 1'b0;
    mmio_doubleword     = 1'b0;
    mmio_address        = '0;
    mmio_address_parity = 1'b1;
    mmio_wdata          = '0;
    mmio_wdata_parity   = 1'b1;
    drive_index         = 0;
    cycle               = 0;
    error_count         = 0;
    ack_count           = 0;
    response_count      = 0;
    build_requests();
    timeout_limit = requests.size() + 30;
    repeat (10) @(posedge clock);
    #1 rstn = 1'b1;
    // Idle cycles show the reset state
    repeat (4) @(posedge clock);
    foreach (requests[i]) begin
      #1 drive_request(i);
      @(posedge clock);
    end
    #1 mmio_valid = 1'b0;
    wait (response_count == requests.size());
    repeat (4) @(posedge clock);
    check_value("ack count", 64'(ack_count), 64'(requests.size()));
    $display("Requests: %0d, acks: %0d, errors: %0d", requests.size(), ack_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+tb
src/capi_pkg.sv
src/parity.sv
src/afu_descriptor.sv
src/mmio_parity_check.sv
src/mmio.sv
src/afu_top.sv
tb/afu_top_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f vlog.f --top-module afu_top_tb -o afu_top_tb

./obj_dir/afu_top_tb | tee sim.log

if grep -q ">>> PASS" sim.log; then
  exit 0
else
  exit 1
fi
